// File: common/wbBackend_config.svh
// Write-back back end sizes
`ifndef WB_BACKEND_CONFIG_SVH
`define WB_BACKEND_CONFIG_SVH

// data and address word width of the RV32 core
`define WB_XLEN 32

// general register file
`define WB_NUM_GPR   32
`define WB_GPR_IDX_W 5

// machine CSRs kept by the back end
`define WB_NUM_CSR   4
`define WB_CSR_IDX_W 2

`define WB_RETIRE_CNT_W 32 // retired instruction counter

`endif

// File: common/wbBackend_pkg.sv
// Write-back back end types
`default_nettype none

`include "wbBackend_config.svh"

package wbBackend_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // memory stage bundle entering write-back
    typedef struct packed {
        logic                       commit;     // one cycle strobe, real instruction
        logic [`WB_XLEN-1:0]        pc;
        logic [`WB_XLEN-1:0]        inst;
        logic [`WB_XLEN-1:0]        aluOut;
        logic [`WB_XLEN-1:0]        csrOut;
        logic [`WB_XLEN-1:0]        loadData;
        logic [`WB_GPR_IDX_W-1:0]   rd;
        logic [`WB_CSR_IDX_W-1:0]   csrIdx;
        logic                       writeGpr;
        logic                       writeCsr;
        logic                       memToReg;   // take loadData instead of aluOut
        logic                       systemHalt;
    } memWbT;

    // ~~~~~~~~~~~~~~~~~~~~
    // register file write requests and the retirement record
    typedef struct packed {
        logic                       en;
        logic [`WB_GPR_IDX_W-1:0]   addr;
        logic [`WB_XLEN-1:0]        data;
    } gprWrT;

    typedef struct packed {
        logic                       en;
        logic [`WB_CSR_IDX_W-1:0]   addr;
        logic [`WB_XLEN-1:0]        data;
    } csrWrT;

    typedef struct packed {
        logic                       valid;
        logic [`WB_XLEN-1:0]        pc;
        logic [`WB_XLEN-1:0]        inst;
    } retireT;

    // index names of the four CSRs
    typedef enum logic [`WB_CSR_IDX_W-1:0] {
        csrMstatus,
        csrMtvec,
        csrMepc,
        csrMcause
    } csrIdxE;

endpackage

`default_nettype wire

// File: regFile/csrFile.sv
// Machine CSR file
`default_nettype none

`include "wbBackend_config.svh"

module csrFile
    import wbBackend_pkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  csrWrT               wr,
    input  csrIdxE              raddr,
    output logic [`WB_XLEN-1:0] rdata
);

    // mstatus, mtvec, mepc and mcause in csrIdxE order
    logic [`WB_XLEN-1:0] regs [`WB_NUM_CSR];

    // ~~~~~~~~~~~~~~~~~~~~
    // single write port

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `WB_NUM_CSR; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdata = regs[raddr];   // combinational read

endmodule

`default_nettype wire

// File: regFile/gprFile.sv
// General purpose register file
`default_nettype none

`include "wbBackend_config.svh"

module gprFile
    import wbBackend_pkg::*;
(
    input  logic                      clk,
    input  logic                      arstN,
    input  gprWrT                     wr,
    input  logic [`WB_GPR_IDX_W-1:0]  raddrA,
    input  logic [`WB_GPR_IDX_W-1:0]  raddrB,
    output logic [`WB_XLEN-1:0]       rdataA,
    output logic [`WB_XLEN-1:0]       rdataB
);

    // x0 has no storage so entries start at index one
    logic [`WB_XLEN-1:0] regs [1:`WB_NUM_GPR-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < `WB_NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;   // a write to x0 falls away here
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read ports as the decode stage sees them

    function automatic logic [`WB_XLEN-1:0] readReg(input logic [`WB_GPR_IDX_W-1:0] idx);
        logic [`WB_XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rdataA = readReg(raddrA);
        rdataB = readReg(raddrB);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the write-back back end simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f wbBackend.f --top-module wbBackend_tb --Mdir obj_dir -o wbBackend_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/wbBackend_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1

// File: source/wbBackendTop.sv
// Write-back back end top
`default_nettype none

`include "wbBackend_config.svh"

module wbBackendTop
    import wbBackend_pkg::*;
(
    input  logic                        clk,
    input  logic                        arstN,
    input  memWbT                       memWb,
    input  logic [`WB_GPR_IDX_W-1:0]    gprRaddrA,
    input  logic [`WB_GPR_IDX_W-1:0]    gprRaddrB,
    output logic [`WB_XLEN-1:0]         gprRdataA,
    output logic [`WB_XLEN-1:0]         gprRdataB,
    input  csrIdxE                      csrRaddr,
    output logic [`WB_XLEN-1:0]         csrRdata,
    output retireT                      retire,
    output logic [`WB_RETIRE_CNT_W-1:0] retiredCount,
    output logic                        halted
);

    // requests before the halt gate
    gprWrT               gprReq;
    csrWrT               csrReq;
    logic                wbCommit;
    logic [`WB_XLEN-1:0] wbPc;
    logic [`WB_XLEN-1:0] wbInst;
    logic                wbHalt;

    gprWrT gprWr;   // gated writes into the register files
    csrWrT csrWr;

    // ~~~~~~~~~~~~~~~~~~~~
    wbStage uWbStage (
        .clk      (clk),
        .arstN    (arstN),
        .memWb    (memWb),
        .gprReq   (gprReq),
        .csrReq   (csrReq),
        .wbCommit (wbCommit),
        .wbPc     (wbPc),
        .wbInst   (wbInst),
        .wbHalt   (wbHalt)
    );

    retireUnit uRetireUnit (
        .clk          (clk),
        .arstN        (arstN),
        .gprReq       (gprReq),
        .csrReq       (csrReq),
        .wbCommit     (wbCommit),
        .wbPc         (wbPc),
        .wbInst       (wbInst),
        .wbHalt       (wbHalt),
        .gprWr        (gprWr),
        .csrWr        (csrWr),
        .retire       (retire),
        .retiredCount (retiredCount),
        .halted       (halted)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    gprFile uGprFile (
        .clk    (clk),
        .arstN  (arstN),
        .wr     (gprWr),
        .raddrA (gprRaddrA),
        .raddrB (gprRaddrB),
        .rdataA (gprRdataA),
        .rdataB (gprRdataB)
    );

    csrFile uCsrFile (
        .clk   (clk),
        .arstN (arstN),
        .wr    (csrWr),
        .raddr (csrRaddr),
        .rdata (csrRdata)
    );

endmodule

`default_nettype wire

// File: testbench/wbBackend_asserts.sv
// Halt and retirement checks
`default_nettype none

`include "wbBackend_config.svh"

module wbBackend_asserts
    import wbBackend_pkg::*;
(
    input logic                        clk,
    input logic                        arstN,
    input gprWrT                       gprWr,
    input csrWrT                       csrWr,
    input retireT                      retire,
    input logic [`WB_RETIRE_CNT_W-1:0] retiredCount,
    input logic                        halted
);
    timeunit 1ns;
    timeprecision 1ps;

    noWriteWhileHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !gprWr.en && !csrWr.en)
        else $error("register write while halted");

    // the halting instruction is the last one to retire
    noRetireAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
        $past(halted) |-> !retire.valid)
        else $error("retirement after halt");

    haltSticky: assert property (@(posedge clk) disable iff (!arstN)
        $past(halted) |-> halted)
        else $error("halted fell without reset");

    countStep: assert property (@(posedge clk) disable iff (!arstN)
        retiredCount == $past(retiredCount) + `WB_RETIRE_CNT_W'(retire.valid))
        else $error("retiredCount did not follow retire");

endmodule

bind retireUnit wbBackend_asserts uAsserts (
    .clk          (clk),
    .arstN        (arstN),
    .gprWr        (gprWr),
    .csrWr        (csrWr),
    .retire       (retire),
    .retiredCount (retiredCount),
    .halted       (halted)
);

`default_nettype wire

// File: testbench/wbBackend_tb.sv
// Write-back back end testbench
`default_nettype none

`include "wbBackend_config.svh"

module wbBackend_tb
    import wbBackend_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TimeoutCycles = 2000;   // roughly four times the whole sequence

    logic                        clk;
    logic                        arstN;
    memWbT                       memWb;
    logic [`WB_GPR_IDX_W-1:0]    gprRaddrA;
    logic [`WB_GPR_IDX_W-1:0]    gprRaddrB;
    logic [`WB_XLEN-1:0]         gprRdataA;
    logic [`WB_XLEN-1:0]         gprRdataB;
    csrIdxE                      csrRaddr;
    logic [`WB_XLEN-1:0]         csrRdata;
    retireT                      retire;
    logic [`WB_RETIRE_CNT_W-1:0] retiredCount;
    logic                        halted;

    // reference model state
    logic [`WB_XLEN-1:0]         shadowGpr [`WB_NUM_GPR];
    logic [`WB_XLEN-1:0]         shadowCsr [`WB_NUM_CSR];
    logic [`WB_RETIRE_CNT_W-1:0] expCount;
    logic                        modelHalted;
    retireT                      retireQ [$];   // retirements still to come with the oldest first

    int errCount;
    int errAtStart;
    int passCount;
    int failCount;
    int cycleCount;

    wbBackendTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // compare tasks

    task automatic checkWord(input string what, input logic [`WB_XLEN-1:0] got,
                             input logic [`WB_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkRetire(input retireT got, input retireT exp);
        if (got !== exp) begin
            $display("[ERROR] %0t retire record: got pc %h inst %h, expected pc %h inst %h",
                     $time, got.pc, got.inst, exp.pc, exp.inst);
            errCount++;
        end
    endtask

    task automatic checkCount(input logic [`WB_RETIRE_CNT_W-1:0] got,
                              input logic [`WB_RETIRE_CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t retiredCount: got %0d, expected %0d", $time, got, exp);
            errCount++;
        end
    endtask

    // every retirement is matched against the oldest queued one
    always @(negedge clk) begin : compareRetire
        retireT exp;
        if (arstN && retire.valid) begin
            if (retireQ.size() == 0) begin
                $display("unexpected retirement at %0t with pc %h", $time, retire.pc);
                errCount++;
            end else begin
                exp = retireQ.pop_front();
                checkRetire(retire, exp);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model and stimulus

    function automatic memWbT randomBundle();
        memWbT b;
        b.commit     = 1'b1;
        b.pc         = $urandom;
        b.inst       = $urandom;
        b.aluOut     = $urandom;
        b.csrOut     = $urandom;
        b.loadData   = $urandom;
        b.rd         = `WB_GPR_IDX_W'($urandom);
        b.csrIdx     = `WB_CSR_IDX_W'($urandom);
        b.writeGpr   = 1'($urandom);
        b.writeCsr   = 1'($urandom);
        b.memToReg   = 1'($urandom);
        b.systemHalt = 1'b0;
        return b;
    endfunction

    // applies one bundle to the model and gives the value meant for rd
    function automatic logic [`WB_XLEN-1:0] modelApply(input memWbT b);
        logic [`WB_XLEN-1:0] val;
        val = b.memToReg ? b.loadData : b.aluOut;
        if (b.commit && !modelHalted) begin
            if (b.writeGpr && b.rd != '0) shadowGpr[b.rd] = val;   // x0 keeps zero
            if (b.writeCsr) shadowCsr[b.csrIdx] = b.csrOut;
            expCount = expCount + 1;
            retireQ.push_back('{valid: 1'b1, pc: b.pc, inst: b.inst});
            if (b.systemHalt) modelHalted = 1'b1;
        end
        return val;
    endfunction

    // called and returning one step after a rising edge
    task automatic sendBundle(input memWbT b);
        void'(modelApply(b));
        memWb = b;
        @(posedge clk);
        #1;
    endtask

    task automatic flush();
        memWbT b;
        repeat (2) begin
            b = randomBundle();
            b.commit = 1'b0;
            sendBundle(b);
        end
    endtask

    task automatic checkAllGpr();
        for (int i = 0; i < `WB_NUM_GPR; i++) begin
            gprRaddrA = `WB_GPR_IDX_W'(i);
            gprRaddrB = `WB_GPR_IDX_W'(`WB_NUM_GPR - 1 - i);   // port B walks downwards
            #2;
            checkWord($sformatf("x%0d port A", i), gprRdataA, shadowGpr[i]);
            checkWord($sformatf("x%0d port B", 31 - i), gprRdataB, shadowGpr[31 - i]);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic checkAllCsr();
        for (int i = 0; i < `WB_NUM_CSR; i++) begin
            csrRaddr = csrIdxE'(i);
            #2;
            checkWord($sformatf("csr %0d", i), csrRdata, shadowCsr[i]);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finishTest(input string name);
        checkCount(retiredCount, expCount);
        if (retireQ.size() != 0) begin
            $display("%0d expected retirements never appeared in %s", retireQ.size(), name);
            errCount++;
            retireQ.delete();
        end
        if (errCount == errAtStart) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errCount - errAtStart);
        end
        errAtStart = errCount;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence

    initial begin
        memWbT b;
        void'($urandom(98678));
        arstN = 1'b0;
        memWb = '0;
        gprRaddrA = '0;
        gprRaddrB = '0;
        csrRaddr = csrMstatus;
        expCount = '0;
        modelHalted = 1'b0;
        errCount = 0;
        errAtStart = 0;
        passCount = 0;
        failCount = 0;
        cycleCount = 0;
        for (int i = 0; i < `WB_NUM_GPR; i++) shadowGpr[i] = '0;
        for (int i = 0; i < `WB_NUM_CSR; i++) shadowCsr[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;

        for (int i = 1; i < 16; i++) begin   // ALU results into x1..x15
            b = randomBundle();
            b.rd = `WB_GPR_IDX_W'(i);
            b.writeGpr = 1'b1;
            b.memToReg = 1'b0;
            b.writeCsr = 1'b0;
            sendBundle(b);
        end
        flush();
        checkAllGpr();
        finishTest("alu write-back");

        for (int i = 16; i < `WB_NUM_GPR; i++) begin
            b = randomBundle();
            b.rd = `WB_GPR_IDX_W'(i);
            b.writeGpr = 1'b1;
            b.memToReg = 1'b1;
            b.writeCsr = 1'b0;
            sendBundle(b);
        end
        for (int i = 0; i < 8; i++) begin
            b = randomBundle();
            b.commit = i[0];   // odd ones commit but carry no GPR write
            b.writeGpr = ~i[0];
            b.writeCsr = 1'b0;
            sendBundle(b);
        end
        flush();
        checkAllGpr();
        finishTest("load write-back");

        for (int i = 0; i < 2; i++) begin
            b = randomBundle();
            b.rd = '0;
            b.writeGpr = 1'b1;
            b.aluOut = 32'hdead_beef;
            b.loadData = 32'hcafe_f00d;
            sendBundle(b);
        end
        flush();
        checkAllGpr();
        finishTest("x0 rule");

        for (int i = 0; i < `WB_NUM_CSR; i++) begin
            b = randomBundle();
            b.csrIdx = `WB_CSR_IDX_W'(i);
            b.writeCsr = 1'b1;
            b.writeGpr = 1'b0;
            sendBundle(b);
        end
        flush();
        checkAllCsr();
        finishTest("csr write");

        for (int i = 0; i < 300; i++) begin
            b = randomBundle();
            b.commit = ($urandom % 4) != 0;
            sendBundle(b);
        end
        flush();
        checkAllGpr();
        checkAllCsr();
        finishTest("random stream");

        b = randomBundle();
        b.rd = 5'd5;
        b.writeGpr = 1'b1;
        b.writeCsr = 1'b1;
        b.systemHalt = 1'b1;
        sendBundle(b);
        for (int i = 0; i < 5; i++) begin   // all of these must be dropped
            b = randomBundle();
            b.rd = `WB_GPR_IDX_W'(i + 1);
            b.writeGpr = 1'b1;
            b.writeCsr = 1'b1;
            sendBundle(b);
        end
        flush();
        checkWord("halted", 32'(halted), 32'(modelHalted));
        checkAllGpr();
        checkAllCsr();
        finishTest("halt");

        $display("tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errCount);
        if (errCount == 0 && failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wbBackend.f
+incdir+common
common/wbBackend_pkg.sv
writeBack/wbStage.sv
writeBack/retireUnit.sv
regFile/gprFile.sv
regFile/csrFile.sv
source/wbBackendTop.sv
testbench/wbBackend_asserts.sv
testbench/wbBackend_tb.sv

// File: writeBack/retireUnit.sv
// Retirement and halt control
`default_nettype none

`include "wbBackend_config.svh"

module retireUnit
    import wbBackend_pkg::*;
(
    input  logic                        clk,
    input  logic                        arstN,
    input  gprWrT                       gprReq,
    input  csrWrT                       csrReq,
    input  logic                        wbCommit,
    input  logic [`WB_XLEN-1:0]         wbPc,
    input  logic [`WB_XLEN-1:0]         wbInst,
    input  logic                        wbHalt,
    output gprWrT                       gprWr,
    output csrWrT                       csrWr,
    output retireT                      retire,
    output logic [`WB_RETIRE_CNT_W-1:0] retiredCount,
    output logic                        halted
);

    logic                retValid;
    logic [`WB_XLEN-1:0] retPc;
    logic [`WB_XLEN-1:0] retInst;
    logic                doRetire;

    // nothing commits once the core has halted
    assign doRetire = wbCommit & ~halted;

    assign gprWr = '{en: gprReq.en & ~halted, addr: gprReq.addr, data: gprReq.data};
    assign csrWr = '{en: csrReq.en & ~halted, addr: csrReq.addr, data: csrReq.data};

    // ~~~~~~~~~~~~~~~~~~~~
    // counter, halt latch and record valid

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retiredCount <= '0;
            halted       <= 1'b0;
            retValid     <= 1'b0;
        end else begin
            retValid <= doRetire;
            if (doRetire) begin
                retiredCount <= retiredCount + 1'b1;
                if (wbHalt) halted <= 1'b1;   // the halting instruction itself retires
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doRetire) begin
            retPc   <= wbPc;
            retInst <= wbInst;
        end
    end

    assign retire = '{valid: retValid, pc: retPc, inst: retInst};

endmodule

`default_nettype wire

// File: writeBack/wbStage.sv
// MEM/WB register and result select
`default_nettype none

`include "wbBackend_config.svh"

module wbStage
    import wbBackend_pkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  memWbT               memWb,
    output gprWrT               gprReq,
    output csrWrT               csrReq,
    output logic                wbCommit,
    output logic [`WB_XLEN-1:0] wbPc,
    output logic [`WB_XLEN-1:0] wbInst,
    output logic                wbHalt
);

    logic  commitQ;   // only control bit of the stage register
    memWbT stageQ;    // payload half, commit field is taken from commitQ

    // ~~~~~~~~~~~~~~~~~~~~
    // MEM/WB pipeline register

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            commitQ <= 1'b0;
        end else begin
            commitQ <= memWb.commit;
        end
    end

    // payload follows every cycle, a bundle with commit low is simply ignored
    always_ff @(posedge clk) begin
        stageQ <= memWb;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // write-back selection

    logic [`WB_XLEN-1:0] gprData;

    always_comb begin
        if (stageQ.memToReg) begin
            gprData = stageQ.loadData;   // load result from the data memory
        end else begin
            gprData = stageQ.aluOut;
        end
    end

    assign gprReq = '{
        en:   commitQ & stageQ.writeGpr,
        addr: stageQ.rd,
        data: gprData
    };

    // the CSR result was already formed in the execute stage
    assign csrReq = '{
        en:   commitQ & stageQ.writeCsr,
        addr: stageQ.csrIdx,
        data: stageQ.csrOut
    };

    assign wbCommit = commitQ;
    assign wbPc     = stageQ.pc;
    assign wbInst   = stageQ.inst;
    assign wbHalt   = stageQ.systemHalt;   // qualified by wbCommit downstream

endmodule

`default_nettype wire
